/* source/cpu_pkg.sv */
package cpu_pkg;

   localparam int WORD_W   = 32;
   localparam int SEL_W    = WORD_W / 8;
   localparam int REG_W    = 4;
   localparam int NUM_REGS = 1 << REG_W;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [SEL_W-1:0]  sel_t;
   typedef logic [REG_W-1:0]  reg_idx_t;

   // instruction class, top nibble of the word
   typedef enum logic [3:0] {
      OP_ALUR = 4'h0,
      OP_ALUI = 4'h1,
      OP_LD   = 4'h2,
      OP_ST   = 4'h3,
      OP_BR   = 4'h4,
      OP_HALT = 4'hf
   } op_t;

   typedef enum logic [3:0] {
      ALU_ADD = 4'h0,
      ALU_SUB = 4'h1,
      ALU_AND = 4'h2,
      ALU_OR  = 4'h3,
      ALU_XOR = 4'h4,
      ALU_SHL = 4'h5,
      ALU_SHR = 4'h6,
      ALU_ASR = 4'h7
   } alu_op_t;

   // func field meaning for branches
   localparam logic [3:0] BR_ALWAYS = 4'h0;
   localparam logic [3:0] BR_EQ     = 4'h1;
   localparam logic [3:0] BR_NE     = 4'h2;
   localparam logic [3:0] BR_LT     = 4'h3;

   localparam int FUNC_BYTE = 0; // func bit for byte load/store

   typedef struct packed {
      op_t         op;
      logic [3:0]  func;
      reg_idx_t    ra;
      reg_idx_t    rb;
      reg_idx_t    rc;
      logic [11:0] pad;
   } instr_r_t;

   typedef struct packed {
      op_t                op;
      logic [3:0]         func;
      reg_idx_t           ra;
      reg_idx_t           rb;
      logic signed [15:0] imm;
   } instr_i_t;

   typedef union packed {
      instr_r_t r;
      instr_i_t i;
   } instr_u;

   typedef logic [2:0] ccr_t;
   localparam int CCR_CARRY = 2;
   localparam int CCR_LT    = 1;
   localparam int CCR_ZERO  = 0;

   typedef enum logic [1:0] {PC_HOLD, PC_NEXT, PC_REL} pc_sel_t;
   typedef enum logic {MAR_HOLD, MAR_ALU} mar_sel_t;
   typedef enum logic {REG_ALU, REG_MDR} reg_sel_t;
   typedef enum logic {ALU2_B, ALU2_IMM} alu2_sel_t;
   typedef enum logic {ADDR_PC, ADDR_MAR} addr_sel_t;

endpackage

/* source/cpu_alu.sv */
module cpu_alu (
   input  cpu_pkg::word_t   in1_i,
   input  cpu_pkg::word_t   in2_i,
   input  cpu_pkg::alu_op_t op_i,
   output cpu_pkg::word_t   out_o,
   output logic             carry_o,
   output logic             lt_o,
   output logic             zero_o
);

   localparam int MSB = cpu_pkg::WORD_W - 1;

   logic [cpu_pkg::WORD_W:0] sum;
   logic [cpu_pkg::WORD_W:0] diff;
   logic                     ovf;
   logic [4:0]               shamt;

   assign sum   = {1'b0, in1_i} + {1'b0, in2_i};
   assign diff  = {1'b0, in1_i} - {1'b0, in2_i};
   assign shamt = in2_i[4:0];

   // signed overflow of in1 - in2
   assign ovf  = (in1_i[MSB] != in2_i[MSB]) && (diff[MSB] != in1_i[MSB]);
   assign lt_o = diff[MSB] ^ ovf;

   always_comb begin
      carry_o = 1'b0;
      case (op_i)
         cpu_pkg::ALU_ADD: begin
            out_o   = sum[MSB:0];
            carry_o = sum[cpu_pkg::WORD_W];
         end
         cpu_pkg::ALU_SUB: begin
            out_o   = diff[MSB:0];
            carry_o = diff[cpu_pkg::WORD_W]; // borrow
         end
         cpu_pkg::ALU_AND: out_o = in1_i & in2_i;
         cpu_pkg::ALU_OR:  out_o = in1_i | in2_i;
         cpu_pkg::ALU_XOR: out_o = in1_i ^ in2_i;
         cpu_pkg::ALU_SHL: out_o = in1_i << shamt;
         cpu_pkg::ALU_SHR: out_o = in1_i >> shamt;
         cpu_pkg::ALU_ASR: out_o = cpu_pkg::word_t'($signed(in1_i) >>> shamt);
         default:          out_o = '0; // undefined func codes
      endcase
   end

   assign zero_o = (out_o == '0);

endmodule

/* source/cpu_regfile.sv */
module cpu_regfile (
   input  logic              clk_i,
   input  logic              rst_i,
   input  cpu_pkg::reg_idx_t read1_i,
   input  cpu_pkg::reg_idx_t read2_i,
   input  cpu_pkg::reg_idx_t write_addr_i,
   input  cpu_pkg::word_t    write_data_i,
   input  logic              write_en_i,
   output cpu_pkg::word_t    data1_o,
   output cpu_pkg::word_t    data2_o
);

   cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (write_en_i && write_addr_i != '0) begin
         regs[write_addr_i] <= write_data_i;
      end
   end

   // r0 is hardwired zero
   assign data1_o = (read1_i == '0) ? '0 : regs[read1_i];
   assign data2_o = (read2_i == '0) ? '0 : regs[read2_i];

endmodule

/* source/cpu_bus_lanes.sv */
module cpu_bus_lanes (
   input  logic           byte_i,
   input  logic [1:0]     addr_lo_i,
   input  cpu_pkg::word_t core_dat_i,
   input  cpu_pkg::word_t bus_dat_i,
   output cpu_pkg::sel_t  sel_o,
   output cpu_pkg::word_t bus_dat_o,
   output cpu_pkg::word_t core_dat_o
);

   logic [7:0] lane; // addressed byte of the read data

   always_comb begin
      case (addr_lo_i)
         2'd0:    lane = bus_dat_i[7:0];
         2'd1:    lane = bus_dat_i[15:8];
         2'd2:    lane = bus_dat_i[23:16];
         default: lane = bus_dat_i[31:24];
      endcase
   end

   // little endian lanes, offset 0 on bits 7:0
   assign sel_o = byte_i ? cpu_pkg::sel_t'(4'b0001 << addr_lo_i) : '1;

   // byte stores put the byte on every lane, sel picks the one written
   assign bus_dat_o = byte_i ? {4{core_dat_i[7:0]}} : core_dat_i;

   assign core_dat_o = byte_i ? {24'h0, lane} : bus_dat_i;

endmodule

/* source/cpu_control.sv */
module cpu_control (
   input  logic                clk_i,
   input  logic                rst_i,
   input  cpu_pkg::instr_u     ir_i,
   input  cpu_pkg::ccr_t       ccr_i,
   input  logic                ack_i,
   input  logic [1:0]          addr_lo_i,
   output logic                ir_write_o,
   output logic                ab_write_o,
   output logic                mdr_write_o,
   output logic                ccr_write_o,
   output cpu_pkg::pc_sel_t    pc_sel_o,
   output cpu_pkg::mar_sel_t   mar_sel_o,
   output cpu_pkg::reg_sel_t   reg_sel_o,
   output cpu_pkg::alu2_sel_t  alu2_sel_o,
   output cpu_pkg::addr_sel_t  addr_sel_o,
   output cpu_pkg::alu_op_t    alu_op_o,
   output cpu_pkg::reg_idx_t   read1_o,
   output cpu_pkg::reg_idx_t   read2_o,
   output cpu_pkg::reg_idx_t   write_addr_o,
   output logic                reg_write_o,
   output logic                byte_o,
   output logic                cyc_o,
   output logic                we_o,
   output logic                halt_o
);

   localparam logic [2:0] S_FETCH     = 3'd0;
   localparam logic [2:0] S_DECODE    = 3'd1;
   localparam logic [2:0] S_EXECUTE   = 3'd2;
   localparam logic [2:0] S_MEMORY    = 3'd3;
   localparam logic [2:0] S_WRITEBACK = 3'd4;
   localparam logic [2:0] S_HALTED    = 3'd5;

   logic [2:0]   state_q;
   logic [2:0]   state_d;
   logic         cyc_q;
   logic         we_q;
   logic         bus_done;
   logic         br_taken;
   logic         is_byte;
   logic         misaligned;
   cpu_pkg::op_t op;

   assign op       = ir_i.r.op;
   assign is_byte  = ir_i.i.func[cpu_pkg::FUNC_BYTE];
   assign bus_done = cyc_q && ack_i;

   // word access off a word boundary stops the core
   assign misaligned = !is_byte && (addr_lo_i != 2'b00);

   always_comb begin
      case (ir_i.i.func)
         cpu_pkg::BR_ALWAYS: br_taken = 1'b1;
         cpu_pkg::BR_EQ:     br_taken = ccr_i[cpu_pkg::CCR_ZERO];
         cpu_pkg::BR_NE:     br_taken = !ccr_i[cpu_pkg::CCR_ZERO];
         cpu_pkg::BR_LT:     br_taken = ccr_i[cpu_pkg::CCR_LT];
         default:            br_taken = 1'b0;
      endcase
   end

   // operand routing depends only on the instruction
   assign read1_o      = ir_i.r.rb;
   assign read2_o      = (op == cpu_pkg::OP_ST) ? ir_i.r.ra : ir_i.r.rc; // store data
   assign write_addr_o = ir_i.r.ra;
   assign alu2_sel_o   = (op == cpu_pkg::OP_ALUR) ? cpu_pkg::ALU2_B : cpu_pkg::ALU2_IMM;
   assign alu_op_o     = (op == cpu_pkg::OP_ALUR || op == cpu_pkg::OP_ALUI) ?
                         cpu_pkg::alu_op_t'(ir_i.r.func) : cpu_pkg::ALU_ADD;

   always_comb begin
      state_d     = state_q;
      ir_write_o  = 1'b0;
      ab_write_o  = 1'b0;
      mdr_write_o = 1'b0;
      ccr_write_o = 1'b0;
      reg_write_o = 1'b0;
      pc_sel_o    = cpu_pkg::PC_HOLD;
      mar_sel_o   = cpu_pkg::MAR_HOLD;
      reg_sel_o   = cpu_pkg::REG_ALU;
      addr_sel_o  = cpu_pkg::ADDR_PC;
      case (state_q)
         S_FETCH: begin
            if (bus_done) begin
               ir_write_o = 1'b1;
               pc_sel_o   = cpu_pkg::PC_NEXT;
               state_d    = S_DECODE;
            end
         end
         S_DECODE: begin
            ab_write_o = 1'b1;
            case (op)
               cpu_pkg::OP_ALUR, cpu_pkg::OP_ALUI, cpu_pkg::OP_LD,
               cpu_pkg::OP_ST, cpu_pkg::OP_BR: state_d = S_EXECUTE;
               cpu_pkg::OP_HALT:               state_d = S_HALTED;
               default:                        state_d = S_HALTED; // unknown class
            endcase
         end
         S_EXECUTE: begin
            case (op)
               cpu_pkg::OP_LD, cpu_pkg::OP_ST: begin
                  mar_sel_o = cpu_pkg::MAR_ALU;
                  state_d   = misaligned ? S_HALTED : S_MEMORY;
               end
               cpu_pkg::OP_BR: begin
                  if (br_taken) begin
                     pc_sel_o = cpu_pkg::PC_REL;
                  end
                  state_d = S_WRITEBACK;
               end
               default: begin
                  ccr_write_o = 1'b1;
                  state_d     = S_WRITEBACK;
               end
            endcase
         end
         S_MEMORY: begin
            addr_sel_o = cpu_pkg::ADDR_MAR;
            if (bus_done) begin
               if (op == cpu_pkg::OP_LD) begin
                  mdr_write_o = 1'b1;
                  state_d     = S_WRITEBACK;
               end else begin
                  state_d = S_FETCH; // idle cycle comes from cyc_q still low
               end
            end
         end
         S_WRITEBACK: begin
            reg_write_o = (op != cpu_pkg::OP_BR);
            reg_sel_o   = (op == cpu_pkg::OP_LD) ? cpu_pkg::REG_MDR : cpu_pkg::REG_ALU;
            state_d     = S_FETCH;
         end
         default: state_d = S_HALTED;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= S_FETCH;
         cyc_q   <= 1'b0;
         we_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         // cycle drops on the ack edge, never runs straight into the next one
         cyc_q   <= (state_d == S_FETCH || state_d == S_MEMORY) && !bus_done;
         we_q    <= (state_d == S_MEMORY) && (op == cpu_pkg::OP_ST) && !bus_done;
      end
   end

   assign cyc_o  = cyc_q;
   assign we_o   = we_q;
   assign byte_o = (state_q == S_MEMORY) && is_byte;
   assign halt_o = (state_q == S_HALTED);

endmodule

/* source/cpu_core.sv */
module cpu_core #(
   parameter cpu_pkg::word_t RESET_PC = '0
) (
   input  logic           clk_i,
   input  logic           rst_i,
   input  logic           ack_i,
   input  cpu_pkg::word_t dat_i,
   output cpu_pkg::word_t adr_o,
   output cpu_pkg::word_t dat_o,
   output logic           cyc_o,
   output logic           we_o,
   output cpu_pkg::sel_t  sel_o,
   output logic           halt_o
);

   // control
   logic                ir_write;
   logic                ab_write;
   logic                mdr_write;
   logic                ccr_write;
   logic                reg_write;
   logic                byte_acc;
   cpu_pkg::pc_sel_t    pc_sel;
   cpu_pkg::mar_sel_t   mar_sel;
   cpu_pkg::reg_sel_t   reg_sel;
   cpu_pkg::alu2_sel_t  alu2_sel;
   cpu_pkg::addr_sel_t  addr_sel;
   cpu_pkg::alu_op_t    alu_op;
   cpu_pkg::reg_idx_t   read1;
   cpu_pkg::reg_idx_t   read2;
   cpu_pkg::reg_idx_t   write_addr;

   // datapath
   cpu_pkg::word_t  pc;
   cpu_pkg::word_t  pc_next;
   cpu_pkg::instr_u ir;
   cpu_pkg::word_t  mar;
   cpu_pkg::word_t  mdr;
   cpu_pkg::word_t  a;
   cpu_pkg::word_t  b;
   cpu_pkg::ccr_t   ccr;
   cpu_pkg::ccr_t   ccr_next;
   cpu_pkg::word_t  imm_sext;
   cpu_pkg::word_t  alu_in2;
   cpu_pkg::word_t  alu_out;
   cpu_pkg::word_t  reg_data_in;
   cpu_pkg::word_t  reg_data1;
   cpu_pkg::word_t  reg_data2;
   cpu_pkg::word_t  load_data;
   logic            alu_carry;
   logic            alu_lt;
   logic            alu_zero;

   assign imm_sext    = {{16{ir.i.imm[15]}}, ir.i.imm};
   assign alu_in2     = (alu2_sel == cpu_pkg::ALU2_IMM) ? imm_sext : b;
   assign reg_data_in = (reg_sel == cpu_pkg::REG_MDR) ? mdr : alu_out;
   assign adr_o       = (addr_sel == cpu_pkg::ADDR_MAR) ? mar : pc;

   always_comb begin
      case (pc_sel)
         cpu_pkg::PC_NEXT: pc_next = pc + 32'd4;
         cpu_pkg::PC_REL:  pc_next = pc + {imm_sext[29:0], 2'b00}; // pc already past the branch
         default:          pc_next = pc;
      endcase
      ccr_next = ccr;
      if (ccr_write) begin
         ccr_next[cpu_pkg::CCR_CARRY] = alu_carry;
         ccr_next[cpu_pkg::CCR_LT]    = alu_lt;
         ccr_next[cpu_pkg::CCR_ZERO]  = alu_zero;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         pc  <= RESET_PC;
         ir  <= '0;
         ccr <= '0;
      end else begin
         pc  <= pc_next;
         ccr <= ccr_next;
         if (ir_write) begin
            ir <= dat_i;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (mar_sel == cpu_pkg::MAR_ALU) begin
         mar <= alu_out;
      end
      if (mdr_write) begin
         mdr <= load_data; // already lane aligned
      end
      if (ab_write) begin
         a <= reg_data1;
         b <= reg_data2;
      end
   end

   cpu_control con0 (
      .clk_i(clk_i), .rst_i(rst_i), .ir_i(ir), .ccr_i(ccr), .ack_i(ack_i),
      .addr_lo_i(alu_out[1:0]), // effective address while in execute
      .ir_write_o(ir_write), .ab_write_o(ab_write), .mdr_write_o(mdr_write),
      .ccr_write_o(ccr_write), .pc_sel_o(pc_sel), .mar_sel_o(mar_sel),
      .reg_sel_o(reg_sel), .alu2_sel_o(alu2_sel), .addr_sel_o(addr_sel),
      .alu_op_o(alu_op), .read1_o(read1), .read2_o(read2),
      .write_addr_o(write_addr), .reg_write_o(reg_write), .byte_o(byte_acc),
      .cyc_o(cyc_o), .we_o(we_o), .halt_o(halt_o)
   );

   cpu_alu alu0 (
      .in1_i(a), .in2_i(alu_in2), .op_i(alu_op), .out_o(alu_out),
      .carry_o(alu_carry), .lt_o(alu_lt), .zero_o(alu_zero)
   );

   cpu_regfile regs0 (
      .clk_i(clk_i), .rst_i(rst_i), .read1_i(read1), .read2_i(read2),
      .write_addr_i(write_addr), .write_data_i(reg_data_in),
      .write_en_i(reg_write), .data1_o(reg_data1), .data2_o(reg_data2)
   );

   cpu_bus_lanes lanes0 (
      .byte_i(byte_acc), .addr_lo_i(adr_o[1:0]), .core_dat_i(b),
      .bus_dat_i(dat_i), .sel_o(sel_o), .bus_dat_o(dat_o),
      .core_dat_o(load_data)
   );

endmodule

/* tests/tb_mem.sv */
module tb_mem #(
   parameter int WORDS = 256
) (
   input  logic           clk_i,
   input  logic           cyc_i,
   input  logic           we_i,
   input  cpu_pkg::sel_t  sel_i,
   input  cpu_pkg::word_t adr_i,
   input  cpu_pkg::word_t dat_i,
   output logic           ack_o,
   output cpu_pkg::word_t dat_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int AW = $clog2(WORDS);

   cpu_pkg::word_t mem [WORDS];
   cpu_pkg::word_t log_dat [$]; // one entry per completed store
   cpu_pkg::sel_t  log_sel [$];
   cpu_pkg::word_t log_adr [$];

   logic           ack_q   = 1'b0;
   cpu_pkg::word_t rdata_q = '0;
   logic           busy    = 1'b0;
   int unsigned    delay   = 0;
   logic [AW-1:0]  idx;

   assign ack_o = ack_q;
   assign dat_o = rdata_q;
   assign idx   = adr_i[AW+1:2];

   // answers on the falling edge, core samples ack on the next rising one
   always @(negedge clk_i) begin
      ack_q <= 1'b0;
      if (cyc_i && !ack_q) begin
         if (!busy) begin
            busy  = 1'b1;
            delay = $urandom_range(3, 0); // wait states for this access
         end
         if (delay == 0) begin
            busy = 1'b0;
            ack_q <= 1'b1;
            if (we_i) begin
               for (int ln = 0; ln < 4; ln++) begin
                  if (sel_i[ln]) begin
                     mem[idx][8*ln +: 8] = dat_i[8*ln +: 8];
                  end
               end
               log_dat.push_back(dat_i);
               log_sel.push_back(sel_i);
               log_adr.push_back(adr_i);
            end else begin
               rdata_q <= mem[idx];
            end
         end else begin
            delay--;
         end
      end
   end

   task automatic clear();
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = 32'hb000_0000 | cpu_pkg::word_t'(i * 4); // decodes as halt
      end
      log_dat.delete();
      log_sel.delete();
      log_adr.delete();
   endtask

   task automatic write_word(input cpu_pkg::word_t adr, input cpu_pkg::word_t data);
      mem[adr[AW+1:2]] = data;
   endtask

   function automatic int store_count();
      return log_dat.size();
   endfunction

   function automatic cpu_pkg::word_t last_dat();
      return log_dat[log_dat.size()-1];
   endfunction

   function automatic cpu_pkg::sel_t last_sel();
      return log_sel[log_sel.size()-1];
   endfunction

   function automatic cpu_pkg::word_t last_adr();
      return log_adr[log_adr.size()-1];
   endfunction

endmodule

/* tests/tb_cpu.sv */
module tb_cpu;
   timeunit 1ns;
   timeprecision 1ps;

   localparam cpu_pkg::word_t PROG_BASE    = 32'h0000_0040;
   localparam logic [15:0]    DATA_ADR     = 16'h0300;
   localparam logic [15:0]    OUT_ADR      = 16'h0310;
   localparam logic [15:0]    MARK_ADR     = 16'h0320;
   localparam int             HALT_TIMEOUT = 2000;

   typedef struct packed {
      cpu_pkg::op_t   op;
      logic [3:0]     func;
      cpu_pkg::word_t x;
      cpu_pkg::word_t y;
      cpu_pkg::word_t exp_word;
      cpu_pkg::word_t exp_adr;
      cpu_pkg::sel_t  exp_sel;
      int             exp_stores;
   } case_t;

   logic           clk;
   logic           rst;
   logic           ack;
   logic           cyc;
   logic           we;
   logic           halt;
   cpu_pkg::sel_t  sel;
   cpu_pkg::word_t adr;
   cpu_pkg::word_t rdata;
   cpu_pkg::word_t wdata;

   case_t          cases [$];
   cpu_pkg::word_t prog [$];
   int             n_err  = 0;
   int             n_fail = 0;

   cpu_core #(.RESET_PC(PROG_BASE)) dut (
      .clk_i(clk), .rst_i(rst), .ack_i(ack), .dat_i(rdata), .adr_o(adr),
      .dat_o(wdata), .cyc_o(cyc), .we_o(we), .sel_o(sel), .halt_o(halt)
   );

   tb_mem #(.WORDS(256)) mem0 (
      .clk_i(clk), .cyc_i(cyc), .we_i(we), .sel_i(sel), .adr_i(adr),
      .dat_i(wdata), .ack_o(ack), .dat_o(rdata)
   );

   always #20 clk = ~clk;

   function automatic cpu_pkg::word_t enc_i(cpu_pkg::op_t op, logic [3:0] func,
                                            int ra, int rb, logic [15:0] imm);
      cpu_pkg::instr_u w;
      w.i.op   = op;
      w.i.func = func;
      w.i.ra   = cpu_pkg::reg_idx_t'(ra);
      w.i.rb   = cpu_pkg::reg_idx_t'(rb);
      w.i.imm  = imm;
      return w;
   endfunction

   function automatic cpu_pkg::word_t enc_r(cpu_pkg::op_t op, logic [3:0] func,
                                            int ra, int rb, int rc);
      cpu_pkg::instr_u w;
      w.r.op   = op;
      w.r.func = func;
      w.r.ra   = cpu_pkg::reg_idx_t'(ra);
      w.r.rb   = cpu_pkg::reg_idx_t'(rb);
      w.r.rc   = cpu_pkg::reg_idx_t'(rc);
      w.r.pad  = '0;
      return w;
   endfunction

   function automatic cpu_pkg::word_t alu_ref(cpu_pkg::alu_op_t f, cpu_pkg::word_t p,
                                              cpu_pkg::word_t q);
      case (f)
         cpu_pkg::ALU_ADD: return p + q;
         cpu_pkg::ALU_SUB: return p - q;
         cpu_pkg::ALU_AND: return p & q;
         cpu_pkg::ALU_OR:  return p | q;
         cpu_pkg::ALU_XOR: return p ^ q;
         cpu_pkg::ALU_SHL: return p << q[4:0];
         cpu_pkg::ALU_SHR: return p >> q[4:0];
         cpu_pkg::ALU_ASR: return cpu_pkg::word_t'($signed(p) >>> q[4:0]);
         default:          return '0;
      endcase
   endfunction

   // branch outcome after sub x - y
   function automatic bit br_ref(logic [3:0] cond, cpu_pkg::word_t p, cpu_pkg::word_t q);
      case (cond)
         cpu_pkg::BR_ALWAYS: return 1'b1;
         cpu_pkg::BR_EQ:     return p == q;
         cpu_pkg::BR_NE:     return p != q;
         cpu_pkg::BR_LT:     return $signed(p) < $signed(q);
         default:            return 1'b0;
      endcase
   endfunction

   task automatic add_case(input cpu_pkg::op_t op, input logic [3:0] func,
                           input cpu_pkg::word_t x, input cpu_pkg::word_t y);
      case_t c;
      c.op         = op;
      c.func       = func;
      c.x          = x;
      c.y          = y;
      c.exp_sel    = 4'hf;
      c.exp_adr    = cpu_pkg::word_t'(DATA_ADR);
      c.exp_stores = 1;
      case (op)
         cpu_pkg::OP_ALUR: c.exp_word = alu_ref(cpu_pkg::alu_op_t'(func), x, y);
         cpu_pkg::OP_ALUI: c.exp_word = alu_ref(cpu_pkg::alu_op_t'(func), x,
                                                {{16{y[15]}}, y[15:0]});
         cpu_pkg::OP_ST: begin
            c.exp_word = {4{x[7:0]}}; // byte on every lane
            c.exp_sel  = 4'b0001 << y[1:0];
            c.exp_adr  = cpu_pkg::word_t'(DATA_ADR) + cpu_pkg::word_t'(y[1:0]);
         end
         cpu_pkg::OP_LD: begin
            c.exp_stores = 2;
            c.exp_adr    = cpu_pkg::word_t'(OUT_ADR);
            c.exp_word   = func[0] ? ((x >> (8 * y[1:0])) & 32'h0000_00ff) : x;
         end
         cpu_pkg::OP_BR: begin
            c.exp_word   = 32'd1;
            c.exp_stores = br_ref(func, x, y) ? 1 : 2; // marker store only when not taken
         end
         default: c.exp_word = '0; // r0 written, then stored
      endcase
      cases.push_back(c);
   endtask

   // upper half pre-adjusted for the sign extended low half
   task automatic load_const(input int rd, input cpu_pkg::word_t v);
      cpu_pkg::word_t hi;
      hi = (v + 32'h0000_8000) >> 16;
      prog.push_back(enc_i(cpu_pkg::OP_ALUI, cpu_pkg::ALU_ADD, rd, 0, hi[15:0]));
      prog.push_back(enc_i(cpu_pkg::OP_ALUI, cpu_pkg::ALU_SHL, rd, rd, 16'd16));
      prog.push_back(enc_i(cpu_pkg::OP_ALUI, cpu_pkg::ALU_ADD, rd, rd, v[15:0]));
   endtask

   task automatic build_program(input case_t c);
      logic [15:0] off;
      off = {14'h0, c.y[1:0]};
      prog.delete();
      case (c.op)
         cpu_pkg::OP_ALUR: begin
            load_const(1, c.x);
            load_const(2, c.y);
            prog.push_back(enc_r(cpu_pkg::OP_ALUR, c.func, 3, 1, 2));
            prog.push_back(enc_i(cpu_pkg::OP_ST, 4'h0, 3, 0, DATA_ADR));
         end
         cpu_pkg::OP_ALUI: begin
            load_const(1, c.x);
            prog.push_back(enc_i(cpu_pkg::OP_ALUI, c.func, 3, 1, c.y[15:0]));
            prog.push_back(enc_i(cpu_pkg::OP_ST, 4'h0, 3, 0, DATA_ADR));
         end
         cpu_pkg::OP_ST: begin
            load_const(1, c.x);
            prog.push_back(enc_i(cpu_pkg::OP_ST, c.func, 1, 0, DATA_ADR + off));
         end
         cpu_pkg::OP_LD: begin
            load_const(1, c.x);
            prog.push_back(enc_i(cpu_pkg::OP_ST, 4'h0, 1, 0, DATA_ADR));
            prog.push_back(enc_i(cpu_pkg::OP_LD, c.func, 2, 0,
                                 DATA_ADR + (c.func[0] ? off : 16'h0)));
            prog.push_back(enc_i(cpu_pkg::OP_ST, 4'h0, 2, 0, OUT_ADR));
         end
         cpu_pkg::OP_BR: begin
            load_const(1, c.x);
            load_const(2, c.y);
            prog.push_back(enc_i(cpu_pkg::OP_ALUI, cpu_pkg::ALU_ADD, 4, 0, 16'd1));
            prog.push_back(enc_r(cpu_pkg::OP_ALUR, cpu_pkg::ALU_SUB, 3, 1, 2));
            prog.push_back(enc_i(cpu_pkg::OP_BR, c.func, 0, 0, 16'd1)); // skip one
            prog.push_back(enc_i(cpu_pkg::OP_ST, 4'h0, 1, 0, MARK_ADR));
            prog.push_back(enc_i(cpu_pkg::OP_ST, 4'h0, 4, 0, DATA_ADR));
         end
         default: begin
            prog.push_back(enc_i(cpu_pkg::OP_ALUI, cpu_pkg::ALU_ADD, 0, 0, 16'h0055));
            prog.push_back(enc_i(cpu_pkg::OP_ST, 4'h0, 0, 0, DATA_ADR));
         end
      endcase
      prog.push_back(enc_r(cpu_pkg::OP_HALT, 4'h0, 0, 0, 0));
      foreach (prog[k]) begin
         mem0.write_word(PROG_BASE + cpu_pkg::word_t'(k * 4), prog[k]);
      end
   endtask

   task automatic check_word(input string what, input cpu_pkg::word_t got,
                             input cpu_pkg::word_t exp);
      if (got !== exp) begin
         $display("ERR %0t: %s stored %h, expected %h", $time, what, got, exp);
         n_err++;
      end
   endtask

   task automatic check_adr(input string what, input cpu_pkg::word_t got,
                            input cpu_pkg::word_t exp);
      if (got !== exp) begin
         $display("ERR %0t: %s stored to %h, expected %h", $time, what, got, exp);
         n_err++;
      end
   endtask

   task automatic check_sel(input string what, input cpu_pkg::sel_t got,
                            input cpu_pkg::sel_t exp);
      if (got !== exp) begin
         $display("ERR %0t: %s sel %b, expected %b", $time, what, got, exp);
         n_err++;
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      if (got != exp) begin
         $display("ERR %0t: %s made %0d stores, expected %0d", $time, what, got, exp);
         n_err++;
      end
   endtask

   task automatic run_case(input int idx, input case_t c);
      int    waited;
      int    errs_before;
      bit    idle_ok;
      string tag;
      errs_before = n_err;
      tag         = $sformatf("case %0d op %0h func %0h", idx, c.op, c.func);
      @(negedge clk);
      rst = 1'b1;
      mem0.clear();
      build_program(c);
      repeat (5) @(negedge clk);
      rst    = 1'b0;
      waited = 0;
      while (halt !== 1'b1 && waited < HALT_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (halt !== 1'b1) begin
         $display("%s hung, no halt after %0d cycles", tag, HALT_TIMEOUT);
         n_err++;
      end else begin
         idle_ok = 1'b1;
         repeat (8) begin
            @(negedge clk);
            idle_ok &= (halt === 1'b1) && (cyc === 1'b0);
         end
         if (!idle_ok) begin
            $display("%s left halt or started a bus cycle after halting", tag);
            n_err++;
         end
         check_count(tag, mem0.store_count(), c.exp_stores);
         if (mem0.store_count() > 0) begin
            check_word(tag, mem0.last_dat(), c.exp_word);
            check_adr(tag, mem0.last_adr(), c.exp_adr);
            check_sel(tag, mem0.last_sel(), c.exp_sel);
         end
      end
      if (n_err != errs_before) begin
         n_fail++;
      end
      $display("%s: %s", tag, (n_err == errs_before) ? "pass" : "fail");
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      void'($urandom(32'hd3d1_e3b4));
      add_case(cpu_pkg::OP_ALUR, cpu_pkg::ALU_ADD, 32'h1234_5678, 32'h0fed_cba9);
      add_case(cpu_pkg::OP_ALUR, cpu_pkg::ALU_SUB, 32'h0000_0010, 32'h0000_0020);
      add_case(cpu_pkg::OP_ALUR, cpu_pkg::ALU_AND, 32'hf0f0_a5a5, 32'h0ff0_3c3c);
      add_case(cpu_pkg::OP_ALUR, cpu_pkg::ALU_OR,  32'hf0f0_a5a5, 32'h0ff0_3c3c);
      add_case(cpu_pkg::OP_ALUR, cpu_pkg::ALU_XOR, 32'hf0f0_a5a5, 32'h0ff0_3c3c);
      add_case(cpu_pkg::OP_ALUR, cpu_pkg::ALU_SHL, 32'h8000_0123, 32'h0000_0024);
      add_case(cpu_pkg::OP_ALUR, cpu_pkg::ALU_SHR, 32'h8000_0123, 32'h0000_0004);
      add_case(cpu_pkg::OP_ALUR, cpu_pkg::ALU_ASR, 32'h8000_0123, 32'h0000_0004);
      add_case(cpu_pkg::OP_ALUI, cpu_pkg::ALU_ADD, 32'd100, 32'hffff_fffd);
      add_case(cpu_pkg::OP_ALUI, cpu_pkg::ALU_AND, 32'h1234_5678, 32'hffff_ff00);
      add_case(cpu_pkg::OP_ALUI, cpu_pkg::ALU_SUB, 32'd5, 32'hffff_fff0);
      add_case(cpu_pkg::OP_LD, 4'h0, 32'hcafe_f00d, 32'd0);
      for (int k = 0; k < 4; k++) begin
         add_case(cpu_pkg::OP_ST, 4'h1, 32'h0000_00a7, cpu_pkg::word_t'(k));
      end
      add_case(cpu_pkg::OP_LD, 4'h1, 32'h8a5c_31f7, 32'd1);
      add_case(cpu_pkg::OP_LD, 4'h1, 32'h8a5c_31f7, 32'd3);
      add_case(cpu_pkg::OP_BR, cpu_pkg::BR_EQ, 32'd7, 32'd7);
      add_case(cpu_pkg::OP_BR, cpu_pkg::BR_EQ, 32'd7, 32'd8);
      add_case(cpu_pkg::OP_BR, cpu_pkg::BR_NE, 32'd7, 32'd8);
      add_case(cpu_pkg::OP_BR, cpu_pkg::BR_NE, 32'd7, 32'd7);
      add_case(cpu_pkg::OP_BR, cpu_pkg::BR_LT, 32'hffff_fffe, 32'd3);
      add_case(cpu_pkg::OP_BR, cpu_pkg::BR_LT, 32'd3, 32'hffff_fffe);
      add_case(cpu_pkg::OP_BR, cpu_pkg::BR_ALWAYS, 32'd1, 32'd2);
      add_case(cpu_pkg::OP_HALT, 4'h0, 32'd0, 32'd0);
      foreach (cases[k]) begin
         run_case(k, cases[k]);
      end
      $display("%0d cases, %0d passed, %0d failed, %0d errors", cases.size(),
               cases.size() - n_fail, n_fail, n_err);
      if (n_err == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* src.f */
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_regfile.sv
source/cpu_bus_lanes.sv
source/cpu_control.sv
source/cpu_core.sv
tests/tb_mem.sv
tests/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
